// ==== logic/bridge_pkg.sv ====
package bridge_pkg;

  // bus widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // cpu position on the bus, top bit marks an active cpu
  typedef logic [31:0] cpu_index_t;

  // inter-cpu message code
  typedef logic [7:0]  cpu_msg_t;

  // cpu control states seen by the bridge
  typedef enum logic [4:0] {
    START_BEGIN, WAIT_FOR_START, FINISH_BEGIN, FINISH_END,
    // read-class states
    READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P, READ_SRC0, READ_SRC0_P,
    READ_DST, START_READ_CMD, START_READ_CMD_P,
    // write-class states
    WRITE_REG_IP, WRITE_DST, WRITE_DST_P, WRITE_SRC1, WRITE_SRC0, WRITE_COND,
    // any other state
    ALU_BEGIN
  } cpu_state_t;

  // registration steps, then normal operation
  typedef enum logic [2:0] {
    REG_CLEAR,
    REG_CHECK,
    REG_CAPTURE,
    REG_RESET_CPU,
    REG_OPEN,
    RUN
  } seq_state_t;

  // message codes on the bus
  localparam cpu_msg_t CPU_R_VOID  = 8'h00;
  localparam cpu_msg_t CPU_R_RESET = 8'h01;
  localparam cpu_msg_t CPU_R_START = 8'h02;
  localparam cpu_msg_t CPU_R_END   = 8'h03;

  // index markers
  localparam cpu_index_t CPU_ACTIVE    = 32'h8000_0000;
  localparam cpu_index_t CPU_NONACTIVE = 32'h0000_0000;

  // thread header size in words
  localparam int THREAD_HEADER_SPACE = 16;

endpackage

// ==== logic/bridge_sequencer.sv ====
`timescale 1ns/1ps

module bridge_sequencer (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_t cpu_state,
  input  logic                   read_q,
  input  logic                   write_q,
  input  bridge_pkg::cpu_index_t ext_cpu_index_in,
  input  logic                   ext_next_cpu_q,
  input  bridge_pkg::cpu_index_t own_index,
  output logic                   granted,
  output logic                   online,
  output logic                   run,
  output logic                   capture_index,
  output logic                   go_nonactive,
  output logic                   release_req,
  output logic                   rst,
  output logic                   ext_rst_e,
  output logic                   ext_dispatcher_q,
  output logic                   ext_read_q,
  output logic                   ext_write_q
);

  bridge_pkg::seq_state_t seq_state;
  // cpu was in FINISH_END during REG_CHECK
  logic finish_seen;
  // this grant already asked for a release
  logic req_seen;
  // release_req one cycle later, same cycle as the bus strobe
  logic release_d;
  logic any_req;

  // states allowed to read over the bus
  function automatic logic is_read_state(input bridge_pkg::cpu_state_t s);
    case (s)
      bridge_pkg::READ_COND,
      bridge_pkg::READ_COND_P,
      bridge_pkg::READ_SRC1,
      bridge_pkg::READ_SRC1_P,
      bridge_pkg::READ_SRC0,
      bridge_pkg::READ_SRC0_P,
      bridge_pkg::READ_DST,
      bridge_pkg::START_READ_CMD,
      bridge_pkg::START_READ_CMD_P: is_read_state = 1'b1;
      default:                      is_read_state = 1'b0;
    endcase
  endfunction

  // states allowed to write over the bus
  function automatic logic is_write_state(input bridge_pkg::cpu_state_t s);
    case (s)
      bridge_pkg::WRITE_REG_IP,
      bridge_pkg::WRITE_DST,
      bridge_pkg::WRITE_DST_P,
      bridge_pkg::WRITE_SRC1,
      bridge_pkg::WRITE_SRC0,
      bridge_pkg::WRITE_COND: is_write_state = 1'b1;
      default:                is_write_state = 1'b0;
    endcase
  endfunction

  // token offered to the index currently on the bus
  assign granted = ext_next_cpu_q && (ext_cpu_index_in == own_index);

  assign run = (seq_state == bridge_pkg::RUN);

  // a finished cpu keeps its nonactive index
  assign capture_index = (seq_state == bridge_pkg::REG_CAPTURE) && !finish_seen;

  // thread done and nobody handing us the token: drop out and register again
  assign go_nonactive = run && (cpu_state == bridge_pkg::FINISH_END) && !granted;

  assign any_req = read_q || write_q;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      seq_state        <= bridge_pkg::REG_CLEAR;
      finish_seen      <= 1'b0;
      online           <= 1'b0;
      req_seen         <= 1'b0;
      release_req      <= 1'b0;
      release_d        <= 1'b0;
      rst              <= 1'b0;
      ext_rst_e        <= 1'b0;
      ext_dispatcher_q <= 1'b0;
      ext_read_q       <= 1'b0;
      ext_write_q      <= 1'b0;
    end else begin
      // single-cycle strobes
      rst         <= 1'b0;
      ext_rst_e   <= 1'b0;
      release_req <= 1'b0;
      release_d   <= release_req;
      ext_read_q  <= 1'b0;
      ext_write_q <= 1'b0;
      case (seq_state)
        bridge_pkg::REG_CLEAR: begin
          online           <= 1'b0;
          req_seen         <= 1'b0;
          ext_dispatcher_q <= 1'b0;
          seq_state        <= bridge_pkg::REG_CHECK;
        end
        bridge_pkg::REG_CHECK: begin
          finish_seen <= (cpu_state == bridge_pkg::FINISH_END);
          seq_state   <= bridge_pkg::REG_CAPTURE;
        end
        bridge_pkg::REG_CAPTURE: begin
          // tracker loads the index this cycle
          seq_state <= bridge_pkg::REG_RESET_CPU;
        end
        bridge_pkg::REG_RESET_CPU: begin
          rst       <= 1'b1;
          // no external reset request after a finished thread
          ext_rst_e <= !finish_seen;
          seq_state <= bridge_pkg::REG_OPEN;
        end
        bridge_pkg::REG_OPEN: begin
          ext_dispatcher_q <= 1'b1;
          seq_state        <= bridge_pkg::RUN;
        end
        bridge_pkg::RUN: begin
          // forward requests only in the matching state class
          ext_read_q  <= online && read_q && is_read_state(cpu_state);
          ext_write_q <= online && write_q && is_write_state(cpu_state);
          if (go_nonactive) begin
            seq_state <= bridge_pkg::REG_CLEAR;
          end
          // grant wins over a pending release
          if (granted) begin
            online   <= 1'b1;
            req_seen <= 1'b0;
          end else if (release_d) begin
            online <= 1'b0;
          end
          // first request of this grant hands the token on
          if (online && any_req && !req_seen) begin
            release_req <= 1'b1;
            req_seen    <= 1'b1;
          end
        end
        default: begin
          seq_state <= bridge_pkg::REG_CLEAR;
        end
      endcase
    end
  end

endmodule

// ==== logic/bus_bridge.sv ====
`timescale 1ns/1ps

module bus_bridge #(
  parameter int THREAD_HEADER_SPACE = bridge_pkg::THREAD_HEADER_SPACE
) (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_t cpu_state,
  input  logic                   read_q,
  input  logic                   write_q,
  input  bridge_pkg::addr_t      addr,
  input  bridge_pkg::data_t      data,
  input  bridge_pkg::cpu_index_t ext_cpu_index_in,
  input  logic                   ext_next_cpu_q,
  input  logic                   ext_next_cpu_e_in,
  input  bridge_pkg::cpu_msg_t   ext_cpu_msg_in,
  output bridge_pkg::addr_t      base_addr,
  output bridge_pkg::addr_t      base_addr_data,
  output logic                   next_state,
  output logic                   rst,
  output logic                   disp_online,
  output logic                   ext_rst_e,
  output logic                   ext_dispatcher_q,
  output logic                   ext_read_q,
  output logic                   ext_write_q,
  output logic                   ext_next_cpu_e,
  output bridge_pkg::cpu_index_t ext_cpu_index,
  output bridge_pkg::cpu_msg_t   ext_cpu_msg
);

  // sequencer to the other blocks
  logic granted;
  logic run;
  logic capture_index;
  logic go_nonactive;
  logic release_req;

  // encoder to broadcast register
  logic                 msg_valid;
  bridge_pkg::cpu_msg_t msg_code;

  // tracked position of this cpu
  bridge_pkg::cpu_index_t own_index;

  // registration, grant, online flag, request gating
  bridge_sequencer u_seq (
    .clk              (clk),
    .ext_rst_b        (ext_rst_b),
    .cpu_state        (cpu_state),
    .read_q           (read_q),
    .write_q          (write_q),
    .ext_cpu_index_in (ext_cpu_index_in),
    .ext_next_cpu_q   (ext_next_cpu_q),
    .own_index        (own_index),
    .granted          (granted),
    .online           (disp_online),
    .run              (run),
    .capture_index    (capture_index),
    .go_nonactive     (go_nonactive),
    .release_req      (release_req),
    .rst              (rst),
    .ext_rst_e        (ext_rst_e),
    .ext_dispatcher_q (ext_dispatcher_q),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q)
  );

  // start and end messages, thread base addresses
  thread_msg_encoder #(
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) u_enc (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .granted        (granted),
    .run            (run),
    .cpu_state      (cpu_state),
    .addr           (addr),
    .data           (data),
    .msg_valid      (msg_valid),
    .msg_code       (msg_code),
    .next_state     (next_state),
    .base_addr      (base_addr),
    .base_addr_data (base_addr_data)
  );

  // outgoing broadcast toward the shared bus
  bus_broadcast_reg u_bcast (
    .clk            (clk),
    .ext_rst_b      (ext_rst_b),
    .msg_valid      (msg_valid),
    .msg_code       (msg_code),
    .release_req    (release_req),
    .own_index      (own_index),
    .ext_cpu_msg    (ext_cpu_msg),
    .ext_cpu_index  (ext_cpu_index),
    .ext_next_cpu_e (ext_next_cpu_e)
  );

  // own index from registration and bus traffic
  cpu_index_tracker u_idx (
    .clk               (clk),
    .ext_rst_b         (ext_rst_b),
    .capture_index     (capture_index),
    .go_nonactive      (go_nonactive),
    .ext_cpu_index_in  (ext_cpu_index_in),
    .ext_cpu_msg_in    (ext_cpu_msg_in),
    .ext_next_cpu_e_in (ext_next_cpu_e_in),
    .cpu_state         (cpu_state),
    .own_index         (own_index)
  );

endmodule

// ==== logic/bus_broadcast_reg.sv ====
`timescale 1ns/1ps

module bus_broadcast_reg (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  logic                   msg_valid,
  input  bridge_pkg::cpu_msg_t   msg_code,
  input  logic                   release_req,
  input  bridge_pkg::cpu_index_t own_index,
  output bridge_pkg::cpu_msg_t   ext_cpu_msg,
  output bridge_pkg::cpu_index_t ext_cpu_index,
  output logic                   ext_next_cpu_e
);

  // one broadcast per cycle, a newer one simply overwrites
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_cpu_msg    <= bridge_pkg::CPU_R_VOID;
      ext_cpu_index  <= bridge_pkg::CPU_NONACTIVE;
      ext_next_cpu_e <= 1'b0;
    end else if (msg_valid) begin
      // message with our index, token goes with it
      ext_cpu_msg    <= msg_code;
      ext_cpu_index  <= own_index;
      ext_next_cpu_e <= 1'b1;
    end else if (release_req) begin
      // token release only
      ext_cpu_msg    <= bridge_pkg::CPU_R_VOID;
      ext_cpu_index  <= bridge_pkg::CPU_NONACTIVE;
      ext_next_cpu_e <= 1'b1;
    end else begin
      // idle, bus lines read as zero
      ext_cpu_msg    <= bridge_pkg::CPU_R_VOID;
      ext_cpu_index  <= bridge_pkg::CPU_NONACTIVE;
      ext_next_cpu_e <= 1'b0;
    end
  end

endmodule

// ==== logic/cpu_index_tracker.sv ====
`timescale 1ns/1ps

module cpu_index_tracker (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  logic                   capture_index,
  input  logic                   go_nonactive,
  input  bridge_pkg::cpu_index_t ext_cpu_index_in,
  input  bridge_pkg::cpu_msg_t   ext_cpu_msg_in,
  input  logic                   ext_next_cpu_e_in,
  input  bridge_pkg::cpu_state_t cpu_state,
  output bridge_pkg::cpu_index_t own_index
);

  logic bus_active;
  logic own_active;
  logic same_index;
  logic msg_start;
  logic msg_end;

  // active flag sits in the top bit
  assign bus_active = ext_cpu_index_in[31];
  assign own_active = own_index[31];
  assign same_index = (ext_cpu_index_in == own_index);
  assign msg_start  = (ext_cpu_msg_in == bridge_pkg::CPU_R_START);
  assign msg_end    = (ext_cpu_msg_in == bridge_pkg::CPU_R_END);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      own_index <= bridge_pkg::CPU_NONACTIVE;
    end else if (go_nonactive) begin
      own_index <= bridge_pkg::CPU_NONACTIVE;
    end else if (capture_index) begin
      // position handed out during registration
      own_index <= ext_cpu_index_in;
    end else if (ext_next_cpu_e_in) begin
      if (same_index) begin
        // own start seen back on the bus while still idle
        if (own_index == bridge_pkg::CPU_NONACTIVE &&
            cpu_state == bridge_pkg::START_BEGIN && msg_start) begin
          own_index <= bridge_pkg::CPU_ACTIVE;
        end
      end else if (!bus_active) begin
        // an idle cpu started a thread, shift our position
        if (msg_start) begin
          if (own_active) begin
            own_index <= own_index + 1'b1;
          end else begin
            own_index <= own_index - 1'b1;
          end
        end
      end else if (own_active && ext_cpu_index_in < own_index && msg_end) begin
        // an active cpu ahead of us finished
        own_index <= own_index - 1'b1;
      end
    end
  end

endmodule

// ==== logic/thread_msg_encoder.sv ====
`timescale 1ns/1ps

module thread_msg_encoder #(
  parameter int THREAD_HEADER_SPACE = bridge_pkg::THREAD_HEADER_SPACE
) (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  logic                   granted,
  input  logic                   run,
  input  bridge_pkg::cpu_state_t cpu_state,
  input  bridge_pkg::addr_t      addr,
  input  bridge_pkg::data_t      data,
  output logic                   msg_valid,
  output bridge_pkg::cpu_msg_t   msg_code,
  output logic                   next_state,
  output bridge_pkg::addr_t      base_addr,
  output bridge_pkg::addr_t      base_addr_data
);

  // header size as an address offset
  localparam bridge_pkg::addr_t HDR_OFS = bridge_pkg::addr_t'(THREAD_HEADER_SPACE);

  logic start_hit;
  logic finish_hit;
  bridge_pkg::addr_t code_base;
  bridge_pkg::addr_t data_base;

  // token held in a state that announces itself
  assign start_hit  = run && granted && (cpu_state == bridge_pkg::WAIT_FOR_START);
  assign finish_hit = run && granted && (cpu_state == bridge_pkg::FINISH_BEGIN);

  // thread code starts past the header
  assign code_base = addr + HDR_OFS;

  // separate data segment if one is given, else share the code segment
  assign data_base = (data != '0) ? bridge_pkg::addr_t'(data) + HDR_OFS : code_base;

  // message and state-advance strobes
  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_valid  <= 1'b0;
      msg_code   <= bridge_pkg::CPU_R_VOID;
      next_state <= 1'b0;
    end else begin
      msg_valid  <= 1'b0;
      msg_code   <= bridge_pkg::CPU_R_VOID;
      next_state <= 1'b0;
      if (start_hit) begin
        msg_valid  <= 1'b1;
        msg_code   <= bridge_pkg::CPU_R_START;
        next_state <= 1'b1;
      end else if (finish_hit) begin
        msg_valid  <= 1'b1;
        msg_code   <= bridge_pkg::CPU_R_END;
        next_state <= 1'b1;
      end
    end
  end

  // base addresses change only on a start
  always_ff @(posedge clk) begin
    if (start_hit) begin
      base_addr      <= code_base;
      base_addr_data <= data_base;
    end
  end

endmodule

// ==== src.f ====
+incdir+include
logic/bridge_pkg.sv
logic/bridge_sequencer.sv
logic/thread_msg_encoder.sv
logic/bus_broadcast_reg.sv
logic/cpu_index_tracker.sv
logic/bus_bridge.sv
tb/tb_bus_bridge.sv

// ==== include/tb_vectors.svh ====
// rows: name, output, cycle after reset release, expected value
// steps below a row drive the inputs on that row's cycles

task automatic load_vectors();
  // outputs straight out of reset
  add_row("reset_online_low", SIG_ONLINE, 0, 32'd0);
  add_row("reset_msg_void", SIG_MSG, 0, bridge_pkg::CPU_R_VOID);
  add_row("reset_release_low", SIG_REL, 0, 32'd0);

  // registration sequence
  add_row("reg_rst_before", SIG_RST, 3, 32'd0);
  add_row("reg_rst_pulse", SIG_RST, 4, 32'd1);
  add_row("reg_rst_e_pulse", SIG_RST_E, 4, 32'd1);
  add_row("reg_rst_after", SIG_RST, 5, 32'd0);
  add_row("reg_disp_closed", SIG_DISP_Q, 4, 32'd0);
  add_row("reg_disp_open", SIG_DISP_Q, 5, 32'd1);
  // finished thread seen in the check step
  add_row("reg_finish_no_rst_e", SIG_RST_E, 4, 32'd0);
  request_at(1, bridge_pkg::FINISH_END, 1'b0, 1'b0);
  add_row("reg_finish_rst", SIG_RST, 4, 32'd1);
  request_at(1, bridge_pkg::FINISH_END, 1'b0, 1'b0);

  // start grant, first cycle in run
  add_row("start_next_state", SIG_NEXT_STATE, 6, 32'd1);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_online", SIG_ONLINE, 6, 32'd1);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_base_addr", SIG_BASE, 6, 32'd0);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_base_data", SIG_BASE_DATA, 6, 32'd0);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_msg", SIG_MSG, 7, bridge_pkg::CPU_R_START);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_index", SIG_IDX, 7, CAP_IDX);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_release", SIG_REL, 7, 32'd1);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  add_row("start_msg_over", SIG_MSG, 8, bridge_pkg::CPU_R_VOID);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);

  // finish grant right after a start, addr and data already changed
  add_row("finish_msg", SIG_MSG, 8, bridge_pkg::CPU_R_END);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  grant_at(6, bridge_pkg::FINISH_BEGIN, CAP_IDX);
  add_row("finish_next_state", SIG_NEXT_STATE, 7, 32'd1);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  grant_at(6, bridge_pkg::FINISH_BEGIN, CAP_IDX);
  add_row("finish_base_kept", SIG_BASE, 8, 32'd0);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  grant_at(6, bridge_pkg::FINISH_BEGIN, CAP_IDX);
  add_row("finish_data_kept", SIG_BASE_DATA, 8, 32'd0);
  grant_at(5, bridge_pkg::WAIT_FOR_START, CAP_IDX);
  grant_at(6, bridge_pkg::FINISH_BEGIN, CAP_IDX);

  // request gating
  add_row("read_forwarded", SIG_READ, 7, 32'd1);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::READ_SRC1, 1'b1, 1'b0);
  add_row("read_release", SIG_REL, 8, 32'd1);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::READ_SRC1, 1'b1, 1'b0);
  add_row("read_goes_offline", SIG_ONLINE, 9, 32'd0);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::READ_SRC1, 1'b1, 1'b0);
  add_row("write_forwarded", SIG_WRITE, 7, 32'd1);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::WRITE_DST, 1'b0, 1'b1);
  add_row("read_wrong_class", SIG_READ, 7, 32'd0);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::WRITE_DST, 1'b1, 1'b0);
  add_row("write_wrong_class", SIG_WRITE, 7, 32'd0);
  grant_at(5, bridge_pkg::ALU_BEGIN, CAP_IDX);
  request_at(6, bridge_pkg::READ_DST, 1'b0, 1'b1);
  add_row("read_offline", SIG_READ, 7, 32'd0);
  request_at(6, bridge_pkg::READ_SRC1, 1'b1, 1'b0);
  add_row("release_offline", SIG_REL, 8, 32'd0);
  request_at(6, bridge_pkg::READ_SRC1, 1'b1, 1'b0);

  // idle cpu starts ahead of us, own index moves up by one
  add_row("track_msg", SIG_MSG, 8, bridge_pkg::CPU_R_START);
  broadcast_at(5, 32'h0000_0002, bridge_pkg::CPU_R_START);
  grant_at(6, bridge_pkg::WAIT_FOR_START, CAP_IDX + 1);
  add_row("track_index", SIG_IDX, 8, CAP_IDX + 1);
  broadcast_at(5, 32'h0000_0002, bridge_pkg::CPU_R_START);
  grant_at(6, bridge_pkg::WAIT_FOR_START, CAP_IDX + 1);
endtask

// ==== tb/tb_bus_bridge.sv ====
`timescale 1ns/1ps

module tb_bus_bridge;

  localparam int RESET_CYCLES = 10;
  localparam int MAX_ROWS     = 64;
  localparam int MAX_STEPS    = 128;
  localparam int HDR_WORDS    = 16;

  // index handed out during registration
  localparam logic [31:0] CAP_IDX = 32'h8000_0003;

  // output selectors for the table
  localparam int SIG_RST        = 0;
  localparam int SIG_RST_E      = 1;
  localparam int SIG_DISP_Q     = 2;
  localparam int SIG_ONLINE     = 3;
  localparam int SIG_NEXT_STATE = 4;
  localparam int SIG_BASE       = 5;
  localparam int SIG_BASE_DATA  = 6;
  localparam int SIG_READ       = 7;
  localparam int SIG_WRITE      = 8;
  localparam int SIG_REL        = 9;
  localparam int SIG_IDX        = 10;
  localparam int SIG_MSG        = 11;

  // addr and data switch to a second value after this cycle
  localparam int ADDR_SWAP_CYC = 5;

  logic                   clk;
  logic                   ext_rst_b;
  bridge_pkg::cpu_state_t cpu_state;
  logic                   read_q;
  logic                   write_q;
  bridge_pkg::addr_t      addr;
  bridge_pkg::data_t      data;
  bridge_pkg::cpu_index_t ext_cpu_index_in;
  logic                   ext_next_cpu_q;
  logic                   ext_next_cpu_e_in;
  bridge_pkg::cpu_msg_t   ext_cpu_msg_in;
  bridge_pkg::addr_t      base_addr;
  bridge_pkg::addr_t      base_addr_data;
  logic                   next_state;
  logic                   rst;
  logic                   disp_online;
  logic                   ext_rst_e;
  logic                   ext_dispatcher_q;
  logic                   ext_read_q;
  logic                   ext_write_q;
  logic                   ext_next_cpu_e;
  bridge_pkg::cpu_index_t ext_cpu_index;
  bridge_pkg::cpu_msg_t   ext_cpu_msg;

  // table rows: one sampled output per row
  string       row_name [0:MAX_ROWS-1];
  int          row_sig  [0:MAX_ROWS-1];
  int          row_ofs  [0:MAX_ROWS-1];
  logic [31:0] row_exp  [0:MAX_ROWS-1];
  int          row_count = 0;

  // per-cycle stimulus, tied to a row
  int                     step_row   [0:MAX_STEPS-1];
  int                     step_cyc   [0:MAX_STEPS-1];
  bridge_pkg::cpu_state_t step_state [0:MAX_STEPS-1];
  logic                   step_rd    [0:MAX_STEPS-1];
  logic                   step_wr    [0:MAX_STEPS-1];
  logic                   step_grant [0:MAX_STEPS-1];
  logic [31:0]            step_idx   [0:MAX_STEPS-1];
  logic                   step_bce   [0:MAX_STEPS-1];
  logic [7:0]             step_msg   [0:MAX_STEPS-1];
  int                     step_count = 0;

  integer      seed = 58;
  logic [31:0] addr_a;
  logic [31:0] addr_b;
  logic [31:0] data_a;
  logic [31:0] data_b;
  int          pass_count = 0;
  int          fail_count = 0;
  int          cycle_count = 0;
  int          timeout_limit = 0;

  bus_bridge #(
    .THREAD_HEADER_SPACE (HDR_WORDS)
  ) dut_i (
    .clk               (clk),
    .ext_rst_b         (ext_rst_b),
    .cpu_state         (cpu_state),
    .read_q            (read_q),
    .write_q           (write_q),
    .addr              (addr),
    .data              (data),
    .ext_cpu_index_in  (ext_cpu_index_in),
    .ext_next_cpu_q    (ext_next_cpu_q),
    .ext_next_cpu_e_in (ext_next_cpu_e_in),
    .ext_cpu_msg_in    (ext_cpu_msg_in),
    .base_addr         (base_addr),
    .base_addr_data    (base_addr_data),
    .next_state        (next_state),
    .rst               (rst),
    .disp_online       (disp_online),
    .ext_rst_e         (ext_rst_e),
    .ext_dispatcher_q  (ext_dispatcher_q),
    .ext_read_q        (ext_read_q),
    .ext_write_q       (ext_write_q),
    .ext_next_cpu_e    (ext_next_cpu_e),
    .ext_cpu_index     (ext_cpu_index),
    .ext_cpu_msg       (ext_cpu_msg)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit from the table length
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count > timeout_limit) begin
      $display("run stopped: %0d cycles passed before all tests finished", timeout_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic add_row(input string name, input int sig, input int ofs,
                         input logic [31:0] exp);
    row_name[row_count] = name;
    row_sig[row_count]  = sig;
    row_ofs[row_count]  = ofs;
    row_exp[row_count]  = exp;
    row_count = row_count + 1;
  endtask

  // stimulus for the most recent row
  task automatic add_step(input int cyc, input bridge_pkg::cpu_state_t st,
                          input logic rd, input logic wr, input logic grant,
                          input logic [31:0] idx, input logic bce, input logic [7:0] msg);
    step_row[step_count]   = row_count - 1;
    step_cyc[step_count]   = cyc;
    step_state[step_count] = st;
    step_rd[step_count]    = rd;
    step_wr[step_count]    = wr;
    step_grant[step_count] = grant;
    step_idx[step_count]   = idx;
    step_bce[step_count]   = bce;
    step_msg[step_count]   = msg;
    step_count = step_count + 1;
  endtask

  task automatic grant_at(input int cyc, input bridge_pkg::cpu_state_t st,
                          input logic [31:0] idx);
    add_step(cyc, st, 1'b0, 1'b0, 1'b1, idx, 1'b0, bridge_pkg::CPU_R_VOID);
  endtask

  task automatic request_at(input int cyc, input bridge_pkg::cpu_state_t st,
                            input logic rd, input logic wr);
    add_step(cyc, st, rd, wr, 1'b0, CAP_IDX, 1'b0, bridge_pkg::CPU_R_VOID);
  endtask

  task automatic broadcast_at(input int cyc, input logic [31:0] idx, input logic [7:0] msg);
    add_step(cyc, bridge_pkg::ALU_BEGIN, 1'b0, 1'b0, 1'b0, idx, 1'b1, msg);
  endtask

  `include "tb_vectors.svh"

  // idle values unless the row gives a step for this cycle
  task automatic apply_step(input int r, input int n);
    int k;
    cpu_state         = bridge_pkg::ALU_BEGIN;
    read_q            = 1'b0;
    write_q           = 1'b0;
    ext_next_cpu_q    = 1'b0;
    ext_cpu_index_in  = CAP_IDX;
    ext_next_cpu_e_in = 1'b0;
    ext_cpu_msg_in    = bridge_pkg::CPU_R_VOID;
    addr = (n <= ADDR_SWAP_CYC) ? addr_a : addr_b;
    data = (n <= ADDR_SWAP_CYC) ? data_a : data_b;
    for (k = 0; k < step_count; k++) begin
      if (step_row[k] == r && step_cyc[k] == n) begin
        cpu_state         = step_state[k];
        read_q            = step_rd[k];
        write_q           = step_wr[k];
        ext_next_cpu_q    = step_grant[k];
        ext_cpu_index_in  = step_idx[k];
        ext_next_cpu_e_in = step_bce[k];
        ext_cpu_msg_in    = step_msg[k];
      end
    end
  endtask

  function automatic logic [31:0] sample_output(input int sig);
    case (sig)
      SIG_RST:        sample_output = {31'd0, rst};
      SIG_RST_E:      sample_output = {31'd0, ext_rst_e};
      SIG_DISP_Q:     sample_output = {31'd0, ext_dispatcher_q};
      SIG_ONLINE:     sample_output = {31'd0, disp_online};
      SIG_NEXT_STATE: sample_output = {31'd0, next_state};
      SIG_BASE:       sample_output = base_addr;
      SIG_BASE_DATA:  sample_output = base_addr_data;
      SIG_READ:       sample_output = {31'd0, ext_read_q};
      SIG_WRITE:      sample_output = {31'd0, ext_write_q};
      SIG_REL:        sample_output = {31'd0, ext_next_cpu_e};
      SIG_IDX:        sample_output = ext_cpu_index;
      SIG_MSG:        sample_output = {24'd0, ext_cpu_msg};
      default:        sample_output = 32'hdead_beef;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (act !== exp) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      fail_count = fail_count + 1;
    end else begin
      $display("ok  %s", name);
      pass_count = pass_count + 1;
    end
  endtask

  // fresh reset, then steps from the release cycle, sample at the row offset
  task automatic run_row(input int r);
    int          n;
    logic [31:0] exp;
    addr_a = $random(seed);
    addr_b = $random(seed);
    data_a = $random(seed);
    data_b = $random(seed);
    @(negedge clk);
    ext_rst_b = 1'b1;
    apply_step(r, 0);
    repeat (RESET_CYCLES) @(negedge clk);
    // base addresses follow the header rule on the first values
    exp = row_exp[r];
    if (row_sig[r] == SIG_BASE) begin
      exp = addr_a + HDR_WORDS;
    end else if (row_sig[r] == SIG_BASE_DATA) begin
      exp = (data_a != 0) ? data_a + HDR_WORDS : addr_a + HDR_WORDS;
    end
    for (n = 0; n <= row_ofs[r]; n++) begin
      if (n > 0) begin
        @(negedge clk);
      end
      if (n == row_ofs[r]) begin
        check_value(row_name[r], exp, sample_output(row_sig[r]));
      end
      ext_rst_b = 1'b0;
      apply_step(r, n);
    end
  endtask

  initial begin
    int r;
    ext_rst_b         = 1'b1;
    cpu_state         = bridge_pkg::ALU_BEGIN;
    read_q            = 1'b0;
    write_q           = 1'b0;
    addr              = '0;
    data              = '0;
    ext_cpu_index_in  = '0;
    ext_next_cpu_q    = 1'b0;
    ext_next_cpu_e_in = 1'b0;
    ext_cpu_msg_in    = bridge_pkg::CPU_R_VOID;
    load_vectors();
    timeout_limit = row_count * 20 + RESET_CYCLES;
    for (r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
